// ==== tb.f ====
rtl/rob_pkg.sv
rtl/retire_if.sv
rtl/reorder_buffer.sv
rtl/arch_map.sv
rtl/retire_core.sv
test/retire_core_properties.sv
test/retire_core_tb.sv

// ==== Bender.yml ====
package:
  name: retire_core

sources:
  - files:
      - rtl/rob_pkg.sv
      - rtl/retire_if.sv
      - rtl/reorder_buffer.sv
      - rtl/arch_map.sv
      - rtl/retire_core.sv
  - target: test
    files:
      - test/retire_core_properties.sv
      - test/retire_core_tb.sv

// ==== test/retire_core_tb.sv ====
`timescale 1ns/1ns

module retire_core_tb;
  import rob_pkg::*;

  localparam int rob_depth = 16;
  localparam int idx_w = $clog2(rob_depth);
  localparam int seed = 78062;
  localparam int stim_cycles = 2000;
  localparam int timeout_limit = 4 * stim_cycles;

  typedef logic [idx_w-1:0] rob_idx_t;

  typedef struct {
    rob_idx_t idx;
    areg_idx_t dest;
    preg_tag_t tag;
    preg_tag_t told;
    bit halt;
    bit illegal;
    bit complete;
  } rob_entry_t;

  logic clock;
  logic reset;
  logic dispatch_en;
  areg_idx_t [num_super-1:0] dispatch_dest;
  preg_tag_t [num_super-1:0] dispatch_tag;
  preg_tag_t [num_super-1:0] dispatch_told;
  logic [num_super-1:0] dispatch_halt;
  logic [num_super-1:0] dispatch_illegal;
  logic [num_super-1:0] complete_en;
  rob_idx_t [num_super-1:0] complete_idx;
  logic rollback_en;
  rob_idx_t rollback_idx;
  areg_idx_t [num_super-1:0] read_areg;
  logic rob_ready;
  rob_idx_t [num_super-1:0] dispatch_idx;
  logic [num_super-1:0] retire_en;
  areg_idx_t [num_super-1:0] retire_dest;
  preg_tag_t [num_super-1:0] retire_tag;
  preg_tag_t [num_super-1:0] retire_told;
  logic halt_out;
  logic illegal_out;
  preg_tag_t [num_super-1:0] read_tag;

  // reference model state
  rob_entry_t entries[$];
  rob_idx_t m_head;
  rob_idx_t m_tail;
  bit m_recovering;
  rob_idx_t m_rb_idx;
  preg_tag_t m_map [num_areg];

  int error_count;
  int check_count;
  int cycle_count;
  int stim_count;
  bit done;

  retire_core #(
    .rob_depth(rob_depth)
  ) DUT (
    .clock(clock),
    .reset(reset),
    .dispatch_en(dispatch_en),
    .dispatch_dest(dispatch_dest),
    .dispatch_tag(dispatch_tag),
    .dispatch_told(dispatch_told),
    .dispatch_halt(dispatch_halt),
    .dispatch_illegal(dispatch_illegal),
    .complete_en(complete_en),
    .complete_idx(complete_idx),
    .rollback_en(rollback_en),
    .rollback_idx(rollback_idx),
    .read_areg(read_areg),
    .rob_ready(rob_ready),
    .dispatch_idx(dispatch_idx),
    .retire_en(retire_en),
    .retire_dest(retire_dest),
    .retire_tag(retire_tag),
    .retire_told(retire_told),
    .halt_out(halt_out),
    .illegal_out(illegal_out),
    .read_tag(read_tag)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic report_counts();
    $display("checks: %0d, errors: %0d", check_count, error_count);
  endtask

  // head entries retire in order, never during a rollback
  function automatic int model_retire_count(input bit rb);
    int n;
    n = 0;
    if (!rb && entries.size() > 0 && entries[0].complete) begin
      n = 1;
      if (entries.size() > 1 && entries[1].complete) begin
        n = 2;
      end
    end
    return n;
  endfunction

  // two slots must be free once this cycle's retirements leave
  function automatic bit model_ready(input bit rb);
    int nret;
    nret = model_retire_count(rb);
    return !m_recovering && !rb && (entries.size() - nret <= rob_depth - num_super);
  endfunction

  task automatic drive_stimulus(input bit draining);
    rob_idx_t pending[$];
    int pick;
    int k;
    bit rb;
    rb = 1'b0;
    if (!draining && !m_recovering && entries.size() > 0 && $urandom_range(99) < 3) begin
      rb = 1'b1;
      k = $urandom_range(entries.size() - 1);
      rollback_idx <= entries[k].idx + 1'b1;
    end
    rollback_en <= rb;
    if (!draining && !rb && model_ready(1'b0) && $urandom_range(99) < 60) begin
      dispatch_en <= 1'b1;
      for (int l = 0; l < num_super; l++) begin
        dispatch_dest[l] <= areg_idx_t'($urandom_range(num_areg - 1));
        dispatch_tag[l] <= preg_tag_t'($urandom_range(num_preg - 1));
        dispatch_told[l] <= preg_tag_t'($urandom_range(num_preg - 1));
        dispatch_halt[l] <= ($urandom_range(99) < 4);
        dispatch_illegal[l] <= ($urandom_range(99) < 4);
      end
    end else begin
      dispatch_en <= 1'b0;
    end
    // outstanding entries, each completed at most once
    foreach (entries[i]) begin
      if (!entries[i].complete) begin
        pending.push_back(entries[i].idx);
      end
    end
    for (int l = 0; l < num_super; l++) begin
      if (pending.size() > 0 && (draining || $urandom_range(99) < 45)) begin
        pick = $urandom_range(pending.size() - 1);
        complete_en[l] <= 1'b1;
        complete_idx[l] <= pending[pick];
        pending.delete(pick);
      end else begin
        complete_en[l] <= 1'b0;
      end
    end
    for (int r = 0; r < num_super; r++) begin
      read_areg[r] <= areg_idx_t'($urandom_range(num_areg - 1));
    end
  endtask

  task automatic check_outputs();
    int nret;
    logic [num_super-1:0] exp_en;
    logic exp_halt;
    logic exp_illegal;
    nret = model_retire_count(rollback_en);
    exp_en = '0;
    exp_halt = 1'b0;
    exp_illegal = 1'b0;
    check_value("rob_ready", model_ready(rollback_en), rob_ready);
    check_value("dispatch_idx[0]", m_tail, dispatch_idx[0]);
    check_value("dispatch_idx[1]", rob_idx_t'(m_tail + 1), dispatch_idx[1]);
    for (int l = 0; l < nret; l++) begin
      exp_en[l] = 1'b1;
      exp_halt = exp_halt | entries[l].halt;
      exp_illegal = exp_illegal | entries[l].illegal;
      check_value($sformatf("retire_dest[%0d]", l), entries[l].dest, retire_dest[l]);
      check_value($sformatf("retire_tag[%0d]", l), entries[l].tag, retire_tag[l]);
      check_value($sformatf("retire_told[%0d]", l), entries[l].told, retire_told[l]);
    end
    check_value("retire_en", exp_en, retire_en);
    check_value("halt_out", exp_halt, halt_out);
    check_value("illegal_out", exp_illegal, illegal_out);
    for (int r = 0; r < num_super; r++) begin
      check_value($sformatf("read_tag[%0d]", r), m_map[read_areg[r]], read_tag[r]);
    end
  endtask

  // what the next rising edge does to the model
  task automatic update_model();
    int nret;
    rob_entry_t e;
    rob_idx_t branch;
    bit found;
    nret = model_retire_count(rollback_en);
    for (int l = 0; l < num_super; l++) begin
      if (complete_en[l]) begin
        foreach (entries[i]) begin
          if (entries[i].idx == complete_idx[l]) begin
            entries[i].complete = 1'b1;
          end
        end
      end
    end
    // lane order, so lane 1 lands last
    for (int l = 0; l < nret; l++) begin
      m_map[entries[0].dest] = entries[0].tag;
      void'(entries.pop_front());
      m_head = m_head + 1'b1;
    end
    if (m_recovering && nret > 0 && m_head == m_rb_idx) begin
      m_recovering = 1'b0;
    end
    if (dispatch_en) begin
      for (int l = 0; l < num_super; l++) begin
        e.idx = rob_idx_t'(m_tail + l);
        e.dest = dispatch_dest[l];
        e.tag = dispatch_tag[l];
        e.told = dispatch_told[l];
        e.halt = dispatch_halt[l];
        e.illegal = dispatch_illegal[l];
        e.complete = dispatch_halt[l] | dispatch_illegal[l];
        entries.push_back(e);
      end
      m_tail = m_tail + rob_idx_t'(num_super);
    end
    if (rollback_en) begin
      branch = rollback_idx - 1'b1;
      found = 1'b0;
      foreach (entries[i]) begin
        if (entries[i].idx == branch) begin
          found = 1'b1;
        end
      end
      if (found) begin
        while (entries[entries.size() - 1].idx != branch) begin
          void'(entries.pop_back());
        end
        m_tail = rollback_idx;
        m_recovering = 1'b1;
        m_rb_idx = rollback_idx;
      end
    end
  endtask

  initial begin
    void'($urandom(seed));
    error_count = 0;
    check_count = 0;
    reset = 1'b1;
    dispatch_en = 1'b0;
    dispatch_dest = '0;
    dispatch_tag = '0;
    dispatch_told = '0;
    dispatch_halt = '0;
    dispatch_illegal = '0;
    complete_en = '0;
    complete_idx = '0;
    rollback_en = 1'b0;
    rollback_idx = '0;
    read_areg = '0;
    m_head = '0;
    m_tail = '0;
    m_recovering = 1'b0;
    m_rb_idx = '0;
    for (int i = 0; i < num_areg; i++) begin
      m_map[i] = preg_tag_t'(i);
    end
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    stim_count = 0;
    done = 1'b0;
    while (!done) begin
      drive_stimulus(stim_count >= stim_cycles);
      @(negedge clock);
      check_outputs();
      update_model();
      stim_count++;
      if (stim_count >= stim_cycles && entries.size() == 0 && !m_recovering) begin
        done = 1'b1;
      end else begin
        @(posedge clock);
      end
    end
    // failed assertions count as errors too
    error_count += DUT.props.fail_count;
    report_counts();
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", timeout_limit);
    report_counts();
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== test/retire_core_properties.sv ====
`timescale 1ns/1ns

module retire_core_properties (
  input logic clock,
  input logic reset,
  input logic dispatch_en,
  input logic rob_ready,
  input logic rollback_en,
  input logic [rob_pkg::num_super-1:0] retire_en,
  input logic halt_out,
  input logic illegal_out,
  input rob_pkg::recover_state_t rob_state
);
  import rob_pkg::*;

  int fail_count = 0;

  lane1_needs_lane0: assert property (@(posedge clock) disable iff (reset)
    retire_en[1] |-> retire_en[0])
    else begin
      fail_count++;
      $error("retire lane 1 fired without lane 0");
    end

  dispatch_needs_ready: assert property (@(posedge clock) disable iff (reset)
    dispatch_en |-> rob_ready)
    else begin
      fail_count++;
      $error("dispatch while rob_ready low");
    end

  no_retire_in_rollback: assert property (@(posedge clock) disable iff (reset)
    rollback_en |-> (retire_en == '0))
    else begin
      fail_count++;
      $error("retirement during rollback");
    end

  flags_need_retire: assert property (@(posedge clock) disable iff (reset)
    (halt_out || illegal_out) |-> (|retire_en))
    else begin
      fail_count++;
      $error("halt or illegal without a retiring lane");
    end

  // recovery only ends on a retiring edge
  recovery_needs_retire: assert property (@(posedge clock) disable iff (reset)
    (rob_state == recovering && !retire_en[0]) |=> (rob_state == recovering))
    else begin
      fail_count++;
      $error("recovery ended without a retirement");
    end

endmodule

bind retire_core retire_core_properties props (
  .clock(clock),
  .reset(reset),
  .dispatch_en(dispatch_en),
  .rob_ready(rob_ready),
  .rollback_en(rollback_en),
  .retire_en(retire_en),
  .halt_out(halt_out),
  .illegal_out(illegal_out),
  .rob_state(rob.state_q)
);

// ==== rtl/retire_core.sv ====
`timescale 1ns/1ns

module retire_core #(
  parameter int rob_depth = 16
) (
  input  logic clock,
  input  logic reset,
  input  logic dispatch_en,
  input  rob_pkg::areg_idx_t [rob_pkg::num_super-1:0] dispatch_dest,
  input  rob_pkg::preg_tag_t [rob_pkg::num_super-1:0] dispatch_tag,
  input  rob_pkg::preg_tag_t [rob_pkg::num_super-1:0] dispatch_told,
  input  logic [rob_pkg::num_super-1:0] dispatch_halt,
  input  logic [rob_pkg::num_super-1:0] dispatch_illegal,
  input  logic [rob_pkg::num_super-1:0] complete_en,
  input  logic [rob_pkg::num_super-1:0][$clog2(rob_depth)-1:0] complete_idx,
  input  logic rollback_en,
  input  logic [$clog2(rob_depth)-1:0] rollback_idx,
  input  rob_pkg::areg_idx_t [rob_pkg::num_super-1:0] read_areg,
  output logic rob_ready,
  output logic [rob_pkg::num_super-1:0][$clog2(rob_depth)-1:0] dispatch_idx,
  output logic [rob_pkg::num_super-1:0] retire_en,
  output rob_pkg::areg_idx_t [rob_pkg::num_super-1:0] retire_dest,
  output rob_pkg::preg_tag_t [rob_pkg::num_super-1:0] retire_tag,
  output rob_pkg::preg_tag_t [rob_pkg::num_super-1:0] retire_told,
  output logic halt_out,
  output logic illegal_out,
  output rob_pkg::preg_tag_t [rob_pkg::num_super-1:0] read_tag
);

  retire_if retire_bus ();

  reorder_buffer #(
    .rob_depth(rob_depth)
  ) rob (
    .clock(clock),
    .reset(reset),
    .dispatch_en(dispatch_en),
    .dispatch_dest(dispatch_dest),
    .dispatch_tag(dispatch_tag),
    .dispatch_told(dispatch_told),
    .dispatch_halt(dispatch_halt),
    .dispatch_illegal(dispatch_illegal),
    .complete_en(complete_en),
    .complete_idx(complete_idx),
    .rollback_en(rollback_en),
    .rollback_idx(rollback_idx),
    .rob_ready(rob_ready),
    .dispatch_idx(dispatch_idx),
    .halt_out(halt_out),
    .illegal_out(illegal_out),
    .retire(retire_bus.rob_side)
  );

  arch_map map (
    .clock(clock),
    .reset(reset),
    .read_areg(read_areg),
    .read_tag(read_tag),
    .retire(retire_bus.map_side)
  );

  // retiring pair also leaves the core, told goes back to the free list
  assign retire_en = retire_bus.retire_en;
  assign retire_dest = retire_bus.retire_dest;
  assign retire_tag = retire_bus.retire_tag;
  assign retire_told = retire_bus.retire_told;

endmodule

// ==== rtl/arch_map.sv ====
`timescale 1ns/1ns

module arch_map (
  input  logic clock,
  input  logic reset,
  input  rob_pkg::areg_idx_t [rob_pkg::num_super-1:0] read_areg,
  output rob_pkg::preg_tag_t [rob_pkg::num_super-1:0] read_tag,
  retire_if.map_side retire
);
  import rob_pkg::*;

  // committed mapping, one tag per architectural register
  preg_tag_t map_q [num_areg];

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map out of reset
      for (int i = 0; i < num_areg; i++) begin
        map_q[i] <= preg_tag_t'(i);
      end
    end else begin
      // later lane is younger, its write lands last
      for (int l = 0; l < num_super; l++) begin
        if (retire.retire_en[l]) begin
          map_q[retire.retire_dest[l]] <= retire.retire_tag[l];
        end
      end
    end
  end

  // read ports see the map as of the last edge
  always_comb begin
    for (int r = 0; r < num_super; r++) begin
      read_tag[r] = map_q[read_areg[r]];
    end
  end

endmodule

// ==== rtl/reorder_buffer.sv ====
`timescale 1ns/1ns

module reorder_buffer #(
  parameter int rob_depth = 16
) (
  input  logic clock,
  input  logic reset,
  input  logic dispatch_en,
  input  rob_pkg::areg_idx_t [rob_pkg::num_super-1:0] dispatch_dest,
  input  rob_pkg::preg_tag_t [rob_pkg::num_super-1:0] dispatch_tag,
  input  rob_pkg::preg_tag_t [rob_pkg::num_super-1:0] dispatch_told,
  input  logic [rob_pkg::num_super-1:0] dispatch_halt,
  input  logic [rob_pkg::num_super-1:0] dispatch_illegal,
  input  logic [rob_pkg::num_super-1:0] complete_en,
  input  logic [rob_pkg::num_super-1:0][$clog2(rob_depth)-1:0] complete_idx,
  input  logic rollback_en,
  input  logic [$clog2(rob_depth)-1:0] rollback_idx,
  output logic rob_ready,
  output logic [rob_pkg::num_super-1:0][$clog2(rob_depth)-1:0] dispatch_idx,
  output logic halt_out,
  output logic illegal_out,
  retire_if.rob_side retire
);
  import rob_pkg::*;

  localparam int idx_w = $clog2(rob_depth);

  typedef logic [idx_w-1:0] rob_idx_t;

  // entry control bits
  logic [rob_depth-1:0] valid_q;
  logic [rob_depth-1:0] valid_next;
  logic [rob_depth-1:0] complete_q;
  logic [rob_depth-1:0] complete_next;

  // entry payload
  areg_idx_t dest_q [rob_depth];
  preg_tag_t tag_q [rob_depth];
  preg_tag_t told_q [rob_depth];
  logic [rob_depth-1:0] halt_q;
  logic [rob_depth-1:0] illegal_q;

  rob_idx_t head_q;
  rob_idx_t head_next;
  rob_idx_t tail_q;
  rob_idx_t tail_next;
  rob_idx_t [num_super-1:0] head_idx;
  rob_idx_t [num_super-1:0] tail_idx;
  rob_idx_t branch_idx;

  recover_state_t state_q;
  recover_state_t state_next;
  rob_idx_t rb_idx_q;
  rob_idx_t rb_idx_next;

  logic [num_super-1:0] retiring;
  logic [rob_depth-1:0] freeing;
  logic do_dispatch;
  logic mispredict;

  always_comb begin
    for (int l = 0; l < num_super; l++) begin
      head_idx[l] = head_q + rob_idx_t'(l);
      tail_idx[l] = tail_q + rob_idx_t'(l);
    end
  end

  assign dispatch_idx = tail_idx;
  assign branch_idx = rollback_idx - 1'b1;

  // a rollback only counts when the branch itself is still in flight
  assign mispredict = rollback_en && valid_q[branch_idx];

  // in-order retirement, each lane needs all older lanes
  always_comb begin
    retiring[0] = valid_q[head_idx[0]] && complete_q[head_idx[0]] && !rollback_en;
    for (int l = 1; l < num_super; l++) begin
      retiring[l] = retiring[l-1] && valid_q[head_idx[l]] && complete_q[head_idx[l]];
    end
  end

  always_comb begin
    freeing = '0;
    for (int l = 0; l < num_super; l++) begin
      if (retiring[l]) begin
        freeing[head_idx[l]] = 1'b1;
      end
    end
  end

  // slots retiring this cycle count as free
  always_comb begin
    rob_ready = (state_q == normal) && !rollback_en;
    for (int l = 0; l < num_super; l++) begin
      if (valid_q[tail_idx[l]] && !freeing[tail_idx[l]]) begin
        rob_ready = 1'b0;
      end
    end
  end

  assign do_dispatch = dispatch_en && rob_ready;

  always_comb begin
    halt_out = 1'b0;
    illegal_out = 1'b0;
    for (int l = 0; l < num_super; l++) begin
      halt_out = halt_out | (retiring[l] & halt_q[head_idx[l]]);
      illegal_out = illegal_out | (retiring[l] & illegal_q[head_idx[l]]);
    end
  end

  always_comb begin
    retire.retire_en = retiring;
    for (int l = 0; l < num_super; l++) begin
      retire.retire_dest[l] = dest_q[head_idx[l]];
      retire.retire_tag[l] = tag_q[head_idx[l]];
      retire.retire_told[l] = told_q[head_idx[l]];
    end
  end

  always_comb begin
    rob_idx_t span;
    rob_idx_t offset;
    valid_next = valid_q;
    complete_next = complete_q;
    head_next = head_q;
    tail_next = tail_q;
    span = tail_q - rollback_idx;
    offset = '0;

    // result bus marks
    for (int l = 0; l < num_super; l++) begin
      if (complete_en[l]) begin
        complete_next[complete_idx[l]] = 1'b1;
      end
    end

    // free retired slots first so a full ROB can refill them this edge
    valid_next = valid_next & ~freeing;
    for (int l = 0; l < num_super; l++) begin
      if (retiring[l]) begin
        head_next = head_idx[l] + 1'b1;
      end
    end

    // paired tail write, halt and illegal need no execution
    if (do_dispatch) begin
      for (int l = 0; l < num_super; l++) begin
        valid_next[tail_idx[l]] = 1'b1;
        complete_next[tail_idx[l]] = dispatch_halt[l] | dispatch_illegal[l];
      end
      tail_next = tail_q + rob_idx_t'(num_super);
    end

    // flush from rollback_idx up to the old tail, wrap aware
    if (mispredict) begin
      for (int i = 0; i < rob_depth; i++) begin
        offset = rob_idx_t'(i) - rollback_idx;
        if (offset < span) begin
          valid_next[i] = 1'b0;
        end
      end
      tail_next = rollback_idx;
    end
  end

  always_comb begin
    state_next = state_q;
    rb_idx_next = rb_idx_q;
    if (mispredict) begin
      state_next = recovering;
      rb_idx_next = rollback_idx;
    end else if (state_q == recovering && retiring[0] && head_next == rb_idx_q) begin
      // branch has left the ROB
      state_next = normal;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
      complete_q <= '0;
      head_q <= '0;
      tail_q <= '0;
      state_q <= normal;
      rb_idx_q <= '0;
    end else begin
      valid_q <= valid_next;
      complete_q <= complete_next;
      head_q <= head_next;
      tail_q <= tail_next;
      state_q <= state_next;
      rb_idx_q <= rb_idx_next;
    end
  end

  always_ff @(posedge clock) begin
    if (do_dispatch) begin
      for (int l = 0; l < num_super; l++) begin
        dest_q[tail_idx[l]] <= dispatch_dest[l];
        tag_q[tail_idx[l]] <= dispatch_tag[l];
        told_q[tail_idx[l]] <= dispatch_told[l];
        halt_q[tail_idx[l]] <= dispatch_halt[l];
        illegal_q[tail_idx[l]] <= dispatch_illegal[l];
      end
    end
  end

endmodule

// ==== rtl/retire_if.sv ====
`timescale 1ns/1ns

interface retire_if;
  import rob_pkg::*;

  // lane 1 only ever retires together with lane 0
  logic [num_super-1:0] retire_en;
  areg_idx_t [num_super-1:0] retire_dest;
  preg_tag_t [num_super-1:0] retire_tag;
  // previous mapping, handed back to the free list
  preg_tag_t [num_super-1:0] retire_told;

  modport rob_side (
    output retire_en,
    output retire_dest,
    output retire_tag,
    output retire_told
  );

  // the map only needs the new mapping
  modport map_side (
    input retire_en,
    input retire_dest,
    input retire_tag
  );

endinterface

// ==== rtl/rob_pkg.sv ====
package rob_pkg;

  // two-wide machine: dispatch, completion and retirement lanes
  localparam int num_super = 2;

  // architectural register file
  localparam int num_areg = 32;
  localparam int areg_w = $clog2(num_areg);

  // physical register file behind the renamer
  localparam int num_preg = 64;
  localparam int preg_w = $clog2(num_preg);

  // physical register tag, also the free list token
  typedef logic [preg_w-1:0] preg_tag_t;

  // architectural register index
  typedef logic [areg_w-1:0] areg_idx_t;

  // dispatch is held off in recovering until the branch retires
  typedef enum logic {
    normal     = 1'b0,
    recovering = 1'b1
  } recover_state_t;

endpackage
